// File: tracker_settings.svh
`ifndef TRACKER_SETTINGS_SVH
`define TRACKER_SETTINGS_SVH

// Active raster of the camera stream
`define HRES 1280
`define VRES 720

// Coordinate widths
`define HCOUNT_W 11
`define VCOUNT_W 10

// Lane 0 tracks the ball and lane 1 the hand
`define NUM_LANES 2

// Ball lane Y window, only bright objects pass
`define BALL_LOWER 8'd240   // Exclusive
`define BALL_UPPER 8'd255   // Inclusive

// Crosshair colours in RGB565
`define MARK_BALL 16'hF800  // Pure red
`define MARK_HAND 16'h07E0  // Pure green

// Classifier pipeline depth in pixel clocks
`define CONV_LAT 3

// Accumulator and divider width
`define DIV_W 32

`endif

// File: video_pkg.sv
`include "tracker_settings.svh"

package video_pkg;

    // One camera pixel in RGB565
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // Raster beat with its position in the frame
    typedef struct packed {
        logic                 valid;
        logic [`HCOUNT_W-1:0] hcount;
        logic [`VCOUNT_W-1:0] vcount;
        rgb565_t              pixel;
    } pix_stream_t;

    // Colour after conversion, each channel clamped to 8 bits
    typedef struct packed {
        logic [7:0] y;
        logic [7:0] cr;
        logic [7:0] cb;
    } ycc_t;

endpackage

// File: track_pkg.sv
`include "tracker_settings.svh"

package track_pkg;

    import video_pkg::*;

    // Channel a lane compares against its window
    typedef enum logic [1:0] {
        CHAN_Y  = 2'd0,
        CHAN_CR = 2'd1
    } chan_sel_e;

    typedef struct packed {
        logic [7:0] lower;  // Exclusive bound
        logic [7:0] upper;  // Inclusive bound
    } window_t;

    // Classified beat handed to the trackers and the overlay
    typedef struct packed {
        logic                  valid;
        logic                  eof;     // Beat at the last frame position
        logic [`HCOUNT_W-1:0]  hcount;
        logic [`VCOUNT_W-1:0]  vcount;
        rgb565_t               pixel;
        logic [`NUM_LANES-1:0] hit;     // One mask bit per lane
    } feat_t;

    typedef struct packed {
        logic                 found;
        logic [`HCOUNT_W-1:0] x;
        logic [`VCOUNT_W-1:0] y;
    } centroid_t;

endpackage

// File: pipe_delay.sv
`timescale 1ns/1ps

module pipe_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk_pixel,
    input  logic sys_rst_pixel,
    input  T     data_i,
    output T     data_o
);

    T stage [DEPTH];    // stage[0] is the newest entry

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= T'('0);
            end
        end else begin
            stage[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign data_o = stage[DEPTH-1];

endmodule

// File: color_classifier.sv
`timescale 1ns/1ps

`include "tracker_settings.svh"

module color_classifier
    import video_pkg::*;
    import track_pkg::*;
(
    input  logic        clk_pixel,
    input  logic        sys_rst_pixel,
    input  pix_stream_t pix_i,
    input  logic [7:0]  sw_i,
    output feat_t       feat_o
);

    localparam chan_sel_e LANE_CHAN [`NUM_LANES] = '{CHAN_Y, CHAN_CR};

    pix_stream_t           pix_d;           // Input beat lined up with stage 3
    logic                  s1_valid, s1_last;
    logic [7:0]            s1_r, s1_g, s1_b;
    logic                  s2_valid, s2_last;
    ycc_t                  s2_ycc;
    logic [`NUM_LANES-1:0] s3_hit;
    logic                  s3_last;
    logic signed [17:0]    r_s, g_s, b_s;
    logic signed [17:0]    y_raw, cr_raw, cb_raw;
    window_t               win [`NUM_LANES];
    logic [`NUM_LANES-1:0] hit_c;

    function automatic logic [7:0] clamp8(input logic signed [17:0] v);
        if (v < 0) begin
            return 8'd0;
        end else if (v > 18'sd255) begin
            return 8'd255;
        end
        return v[7:0];
    endfunction

    function automatic logic [7:0] pick(input chan_sel_e sel, input ycc_t c);
        case (sel)
            CHAN_CR: return c.cr;
            default: return c.y;
        endcase
    endfunction

    pipe_delay #(
        .T     (pix_stream_t),
        .DEPTH (`CONV_LAT)
    ) pix_delay (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .data_i        (pix_i),
        .data_o        (pix_d)
    );

    // Stage 1 widens each colour to 8 bits
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= pix_i.valid;
            s1_last  <= pix_i.valid && pix_i.hcount == `HCOUNT_W'(`HRES - 1)
                        && pix_i.vcount == `VCOUNT_W'(`VRES - 1);
        end
        s1_r <= {pix_i.pixel.red, 3'b000};
        s1_g <= {pix_i.pixel.green, 2'b00};
        s1_b <= {pix_i.pixel.blue, 3'b000};
    end

    assign r_s = 18'(s1_r);
    assign g_s = 18'(s1_g);
    assign b_s = 18'(s1_b);

    // Fixed-point BT.601 weights scaled by 256
    assign y_raw  = ((18'sd66 * r_s + 18'sd129 * g_s + 18'sd25 * b_s + 18'sd128) >>> 8)
                    + 18'sd16;
    assign cr_raw = ((18'sd112 * r_s - 18'sd94 * g_s - 18'sd18 * b_s + 18'sd128) >>> 8)
                    + 18'sd128;
    assign cb_raw = ((18'sd112 * b_s - 18'sd38 * r_s - 18'sd74 * g_s + 18'sd128) >>> 8)
                    + 18'sd128;

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            s2_valid <= 1'b0;
            s2_last  <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
            s2_last  <= s1_last;
        end
        s2_ycc.y  <= clamp8(y_raw);
        s2_ycc.cr <= clamp8(cr_raw);
        s2_ycc.cb <= clamp8(cb_raw);
    end

    // Window test per lane
    always_comb begin
        logic [7:0] chan;
        win[0] = '{lower: `BALL_LOWER, upper: `BALL_UPPER};
        win[1] = '{lower: {sw_i[3:0], 4'h0}, upper: {sw_i[7:4], 4'hF}};  // Hand window from switches
        for (int l = 0; l < `NUM_LANES; l++) begin
            chan     = pick(LANE_CHAN[l], s2_ycc);
            hit_c[l] = s2_valid && chan > win[l].lower && chan <= win[l].upper;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            s3_hit  <= '0;
            s3_last <= 1'b0;
        end else begin
            s3_hit  <= hit_c;
            s3_last <= s2_last;
        end
    end

    always_comb begin
        feat_o.valid  = pix_d.valid;
        feat_o.eof    = s3_last;
        feat_o.hcount = pix_d.hcount;
        feat_o.vcount = pix_d.vcount;
        feat_o.pixel  = pix_d.pixel;
        feat_o.hit    = s3_hit;
    end

endmodule

// File: centroid_tracker.sv
`timescale 1ns/1ps

`include "tracker_settings.svh"

module centroid_tracker
    import track_pkg::*;
(
    input  logic      clk_pixel,
    input  logic      sys_rst_pixel,
    input  feat_t     feat_i,
    input  logic      hit_i,
    output centroid_t centroid_o,
    output logic      centroid_valid_o
);

    localparam int W = `DIV_W;

    logic                 beat_hit, frame_end;
    logic [W-1:0]         add_x, add_y, add_n;        // Contribution of the current beat
    logic [W-1:0]         acc_x, acc_y, acc_n;
    logic [W-1:0]         frame_x, frame_y, frame_n;  // Frame totals including this beat
    logic [W-1:0]         rem_x, quo_x, rem_y, quo_y;
    logic [W-1:0]         divisor;                    // Hit count of the frame being divided
    logic [2*W-1:0]       next_x, next_y;
    logic [$clog2(W)-1:0] step;
    logic                 busy, empty_frame;

    // One restoring step, returns the new remainder and quotient
    function automatic logic [2*`DIV_W-1:0] div_step(
        input logic [`DIV_W-1:0] rem,
        input logic [`DIV_W-1:0] quo,
        input logic [`DIV_W-1:0] den
    );
        logic [`DIV_W:0] shifted;
        logic [`DIV_W:0] diff;
        shifted = {rem, quo[`DIV_W-1]};
        diff    = shifted - {1'b0, den};
        if (!diff[`DIV_W]) begin
            return {diff[`DIV_W-1:0], quo[`DIV_W-2:0], 1'b1};
        end
        return {shifted[`DIV_W-1:0], quo[`DIV_W-2:0], 1'b0};
    endfunction

    assign beat_hit  = feat_i.valid && hit_i;
    assign frame_end = feat_i.valid && feat_i.eof;

    assign add_x = beat_hit ? W'(feat_i.hcount) : '0;
    assign add_y = beat_hit ? W'(feat_i.vcount) : '0;
    assign add_n = beat_hit ? W'(1) : '0;

    assign frame_x = acc_x + add_x;
    assign frame_y = acc_y + add_y;
    assign frame_n = acc_n + add_n;

    // Accumulators restart right after the last beat of each frame
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel || frame_end) begin
            acc_x <= '0;
            acc_y <= '0;
            acc_n <= '0;
        end else begin
            acc_x <= frame_x;
            acc_y <= frame_y;
            acc_n <= frame_n;
        end
    end

    assign next_x = div_step(rem_x, quo_x, divisor);
    assign next_y = div_step(rem_y, quo_y, divisor);

    // Divider datapath, x and y share the divisor
    always_ff @(posedge clk_pixel) begin
        if (frame_end) begin
            quo_x   <= frame_x;
            quo_y   <= frame_y;
            rem_x   <= '0;
            rem_y   <= '0;
            divisor <= frame_n;
        end else if (busy) begin
            {rem_x, quo_x} <= next_x;
            {rem_y, quo_y} <= next_y;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            busy             <= 1'b0;
            step             <= '0;
            empty_frame      <= 1'b0;
            centroid_o       <= '0;
            centroid_valid_o <= 1'b0;
        end else begin
            centroid_valid_o <= 1'b0;
            empty_frame      <= 1'b0;
            if (frame_end) begin
                busy        <= frame_n != '0;
                empty_frame <= frame_n == '0;   // No hits, report next cycle
                step        <= '0;
            end else if (busy) begin
                step <= step + $bits(step)'(1);
                if (step == $bits(step)'(W - 1)) begin    // Last quotient bit this cycle
                    busy             <= 1'b0;
                    centroid_valid_o <= 1'b1;
                    centroid_o.found <= 1'b1;
                    centroid_o.x     <= next_x[`HCOUNT_W-1:0];
                    centroid_o.y     <= next_y[`VCOUNT_W-1:0];
                end
            end
            if (empty_frame) begin
                centroid_valid_o <= 1'b1;
                centroid_o       <= '0;
            end
        end
    end

endmodule

// File: crosshair_overlay.sv
`timescale 1ns/1ps

`include "tracker_settings.svh"

module crosshair_overlay
    import video_pkg::*;
    import track_pkg::*;
(
    input  logic                       clk_pixel,
    input  logic                       sys_rst_pixel,
    input  feat_t                      feat_i,
    input  centroid_t [`NUM_LANES-1:0] centroid_i,
    input  logic [`NUM_LANES-1:0]      centroid_valid_i,
    output pix_stream_t                pix_o
);

    localparam rgb565_t LANE_MARK [`NUM_LANES] = '{
        rgb565_t'(`MARK_BALL),
        rgb565_t'(`MARK_HAND)
    };

    centroid_t [`NUM_LANES-1:0] held;   // Last reported result per lane
    rgb565_t                    paint;

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            held <= '0;
        end else begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (centroid_valid_i[l]) begin
                    held[l] <= centroid_i[l];
                end
            end
        end
    end

    // Walk from the highest lane down so lane 0 has the last word
    always_comb begin
        paint = feat_i.pixel;
        for (int l = `NUM_LANES - 1; l >= 0; l--) begin
            if (feat_i.valid && held[l].found
                && (feat_i.hcount == held[l].x || feat_i.vcount == held[l].y)) begin
                paint = LANE_MARK[l];
            end
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            pix_o.valid <= 1'b0;
        end else begin
            pix_o.valid <= feat_i.valid;
        end
        pix_o.hcount <= feat_i.hcount;
        pix_o.vcount <= feat_i.vcount;
        pix_o.pixel  <= paint;
    end

endmodule

// File: tracker_top.sv
`timescale 1ns/1ps

`include "tracker_settings.svh"

module tracker_top
    import video_pkg::*;
    import track_pkg::*;
(
    input  logic                       clk_pixel,
    input  logic                       sys_rst_pixel,
    input  pix_stream_t                pix_i,
    input  logic [7:0]                 sw_i,              // Hand window bounds
    output pix_stream_t                pix_o,
    output centroid_t [`NUM_LANES-1:0] centroid_o,
    output logic [`NUM_LANES-1:0]      centroid_valid_o
);

    feat_t feat;    // Classified stream shared by all lanes

    color_classifier classifier_inst (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .pix_i         (pix_i),
        .sw_i          (sw_i),
        .feat_o        (feat)
    );

    generate
        for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
            centroid_tracker tracker_inst (
                .clk_pixel        (clk_pixel),
                .sys_rst_pixel    (sys_rst_pixel),
                .feat_i           (feat),
                .hit_i            (feat.hit[g]),
                .centroid_o       (centroid_o[g]),
                .centroid_valid_o (centroid_valid_o[g])
            );
        end
    endgenerate

    crosshair_overlay overlay_inst (
        .clk_pixel        (clk_pixel),
        .sys_rst_pixel    (sys_rst_pixel),
        .feat_i           (feat),
        .centroid_i       (centroid_o),
        .centroid_valid_i (centroid_valid_o),
        .pix_o            (pix_o)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset drops just after the last reset edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

// File: tracker_tb.sv
`timescale 1ns/1ps

`include "tracker_settings.svh"

module tracker_tb
    import video_pkg::*;
    import track_pkg::*;
();

    localparam int PERIOD_NS    = 100;
    localparam int RESET_CYCLES = 16;
    localparam int PIPE_LAT     = `CONV_LAT + 1;
    localparam int FRAME_GAP    = `DIV_W + 8;     // Divider run plus the overlay update
    localparam int NUM_FRAMES   = 7;
    localparam int MAX_BEATS    = 32;             // Upper bound per frame, closing beat included
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + NUM_FRAMES * (MAX_BEATS + `DIV_W + 20)) * PERIOD_NS;

    logic                       clk_pixel;
    logic                       sys_rst_pixel;
    pix_stream_t                pix_i;
    pix_stream_t                pix_o;
    logic [7:0]                 sw_i;
    centroid_t [`NUM_LANES-1:0] centroid_o;
    logic [`NUM_LANES-1:0]      centroid_valid_o;

    pix_stream_t exp_q [$];                 // One expected pix_o per driven cycle
    pix_stream_t exp_pix;
    pix_stream_t frame_q [$];
    centroid_t   cent_q [`NUM_LANES][$];
    centroid_t   exp_cent [`NUM_LANES];
    centroid_t   model_held [`NUM_LANES];   // What the overlay should be holding
    logic        model_live;
    int          reports_seen;
    int          mismatch_count;
    int          other_count;

    tb_clock_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) clock_gen_inst (
        .clk_o (clk_pixel),
        .rst_o (sys_rst_pixel)
    );

    tracker_top tracker_top_inst (
        .clk_pixel        (clk_pixel),
        .sys_rst_pixel    (sys_rst_pixel),
        .pix_i            (pix_i),
        .sw_i             (sw_i),
        .pix_o            (pix_o),
        .centroid_o       (centroid_o),
        .centroid_valid_o (centroid_valid_o)
    );

    function automatic int saturate_u8(input int v);
        return (v < 0) ? 0 : ((v > 255) ? 255 : v);
    endfunction

    // Lane 0 tests Y against the ball window, lane 1 tests Cr against the switch window
    function automatic logic [`NUM_LANES-1:0] lane_hits(input rgb565_t p);
        int r;
        int g;
        int b;
        int y;
        int cr;
        logic [`NUM_LANES-1:0] hits;
        r  = int'(p.red) * 8;
        g  = int'(p.green) * 4;
        b  = int'(p.blue) * 8;
        y  = saturate_u8(((66 * r + 129 * g + 25 * b + 128) >>> 8) + 16);
        cr = saturate_u8(((112 * r - 94 * g - 18 * b + 128) >>> 8) + 128);
        hits    = '0;
        hits[0] = y > int'(`BALL_LOWER) && y <= int'(`BALL_UPPER);
        hits[1] = cr > int'({sw_i[3:0], 4'h0}) && cr <= int'({sw_i[7:4], 4'hF});
        return hits;
    endfunction

    function automatic pix_stream_t expected_out(input pix_stream_t beat);
        pix_stream_t o;
        logic        on_ball;
        logic        on_hand;
        o       = beat;
        on_ball = model_held[0].found
                  && (beat.hcount == model_held[0].x || beat.vcount == model_held[0].y);
        on_hand = model_held[1].found
                  && (beat.hcount == model_held[1].x || beat.vcount == model_held[1].y);
        if (beat.valid && on_ball) begin
            o.pixel = rgb565_t'(`MARK_BALL);
        end else if (beat.valid && on_hand) begin
            o.pixel = rgb565_t'(`MARK_HAND);
        end
        return o;
    endfunction

    task automatic drive_beat(input pix_stream_t beat);
        @(posedge clk_pixel);
        #1;
        pix_i = beat;
        exp_q.push_back(expected_out(beat));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_beat('0);
    endtask

    task automatic add_beat(input int x, input int y, input logic [15:0] colour);
        pix_stream_t b;
        b.valid  = 1'b1;
        b.hcount = `HCOUNT_W'(x);
        b.vcount = `VCOUNT_W'(y);
        b.pixel  = rgb565_t'(colour);
        frame_q.push_back(b);
    endtask

    // Last row is kept free so only the closing beat flags end of frame
    task automatic add_random_beat(input logic [15:0] colour);
        add_beat($urandom % `HRES, $urandom % (`VRES - 1), colour);
    endtask

    task automatic send_frame();
        int                    sum_x [`NUM_LANES];
        int                    sum_y [`NUM_LANES];
        int                    count [`NUM_LANES];
        logic [`NUM_LANES-1:0] hits;
        centroid_t             result [`NUM_LANES];
        for (int l = 0; l < `NUM_LANES; l++) begin
            sum_x[l] = 0;
            sum_y[l] = 0;
            count[l] = 0;
        end
        add_beat(`HRES - 1, `VRES - 1, 16'h0000);   // Closing beat is always black
        foreach (frame_q[i]) begin
            hits = lane_hits(frame_q[i].pixel);
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (hits[l]) begin
                    sum_x[l] += int'(frame_q[i].hcount);
                    sum_y[l] += int'(frame_q[i].vcount);
                    count[l]++;
                end
            end
            drive_beat(frame_q[i]);
        end
        frame_q.delete();
        for (int l = 0; l < `NUM_LANES; l++) begin
            result[l] = '0;
            if (count[l] != 0) begin
                result[l].found = 1'b1;
                result[l].x     = `HCOUNT_W'(sum_x[l] / count[l]);
                result[l].y     = `VCOUNT_W'(sum_y[l] / count[l]);
            end
            cent_q[l].push_back(result[l]);
        end
        idle_cycles(FRAME_GAP);
        for (int l = 0; l < `NUM_LANES; l++) begin
            if (cent_q[l].size() != 0) begin
                other_count++;
                $display("Lane %0d gave no centroid pulse within %0d cycles of frame end",
                         l, FRAME_GAP);
                cent_q[l].delete();
            end
            model_held[l] = result[l];
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // Expected values settle at the falling edge, assertions sample them at the rising one
    always @(negedge clk_pixel) begin
        if (exp_q.size() > PIPE_LAT) begin
            exp_pix    = exp_q.pop_front();
            model_live = 1'b1;
        end
        for (int l = 0; l < `NUM_LANES; l++) begin
            if (centroid_valid_o[l] === 1'b1) begin
                reports_seen++;
                if (cent_q[l].size() == 0) begin
                    other_count++;
                    $display("Lane %0d gave an unexpected centroid pulse at %0t", l, $time);
                end else begin
                    exp_cent[l] = cent_q[l].pop_front();
                end
            end
        end
    end

    assert property (@(posedge clk_pixel) !model_live || pix_o.valid == exp_pix.valid)
        else begin
            mismatch_count++;
            $display("Mismatch at %0t: pix_o valid %b, expected %b",
                     $time, $sampled(pix_o.valid), exp_pix.valid);
        end

    assert property (@(posedge clk_pixel) !model_live || !exp_pix.valid
                     || (pix_o.hcount == exp_pix.hcount && pix_o.vcount == exp_pix.vcount))
        else begin
            mismatch_count++;
            $display("Mismatch at %0t: pix_o at (%0d,%0d), expected (%0d,%0d)", $time,
                     $sampled(pix_o.hcount), $sampled(pix_o.vcount),
                     exp_pix.hcount, exp_pix.vcount);
        end

    assert property (@(posedge clk_pixel) !model_live || !exp_pix.valid
                     || pix_o.pixel == exp_pix.pixel)
        else begin
            mismatch_count++;
            $display("Mismatch at %0t: pixel %h at (%0d,%0d), expected %h", $time,
                     $sampled(pix_o.pixel), exp_pix.hcount, exp_pix.vcount, exp_pix.pixel);
        end

    for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane_chk
        assert property (@(posedge clk_pixel) !model_live || !centroid_valid_o[l]
                         || centroid_o[l] == exp_cent[l])
            else begin
                mismatch_count++;
                $display("Mismatch at %0t: lane %0d found %b x %0d y %0d, expected %b %0d %0d",
                         $time, l, $sampled(centroid_o[l].found), $sampled(centroid_o[l].x),
                         $sampled(centroid_o[l].y), exp_cent[l].found, exp_cent[l].x,
                         exp_cent[l].y);
            end

        assert property (@(posedge clk_pixel) !model_live || reports_seen != 0
                         || !centroid_o[l].found)
            else begin
                mismatch_count++;
                $display("Mismatch at %0t: lane %0d found flag set before any report",
                         $time, l);
            end
    end

    initial begin
        int cross_x;
        int cross_y;
        pix_i          = '0;
        sw_i           = 8'hEE;     // Hand window (224, 239], black Cr 128 stays outside
        exp_pix        = '0;
        model_live     = 1'b0;
        reports_seen   = 0;
        mismatch_count = 0;
        other_count    = 0;
        for (int l = 0; l < `NUM_LANES; l++) begin
            model_held[l] = '0;
            exp_cent[l]   = '0;
        end
        void'($urandom(80));
        idle_cycles(RESET_CYCLES + 2);

        send_frame();   // No hits at all

        // White expands to 248/252/248, so its Y of 231 stays below the ball window
        repeat (12) add_random_beat(16'hFFFF);
        send_frame();

        repeat (10) add_random_beat(16'hF800);  // Saturated red, Cr 237
        send_frame();

        // Beats on the hand crosshair plus random colours elsewhere
        for (int i = 0; i < 6; i++) begin
            add_beat(int'(model_held[1].x), $urandom % (`VRES - 1), 16'($urandom));
            add_beat($urandom % `HRES, int'(model_held[1].y), 16'($urandom));
        end
        repeat (8) add_random_beat(16'($urandom));
        send_frame();

        repeat (8) add_random_beat(16'hF800);
        repeat (8) add_random_beat(16'hFFFF);
        send_frame();

        // Black beats on the last crosshair, marked now and plain once it is cleared
        cross_x = int'(model_held[1].x);
        cross_y = int'(model_held[1].y);
        for (int f = 0; f < 2; f++) begin
            for (int i = 0; i < 3; i++) begin
                add_beat(cross_x, $urandom % (`VRES - 1), 16'h0000);
                add_beat($urandom % `HRES, cross_y, 16'h0000);
            end
            send_frame();
        end

        finish_run();
    end

    initial begin
        #(WATCHDOG_NS);
        other_count++;
        $display("Watchdog expired after %0d ns before all frames were checked", WATCHDOG_NS);
        finish_run();
    end

endmodule

// File: sources.f
+incdir+.
video_pkg.sv
track_pkg.sv
pipe_delay.sv
color_classifier.sv
centroid_tracker.sv
crosshair_overlay.sv
tracker_top.sv
tb_clock_gen.sv
tracker_tb.sv

// File: Makefile
# Verilator flow for the object tracker

VERILATOR  ?= verilator
FILELIST   ?= sources.f
TB_TOP     ?= tracker_tb
RTL_TOP    ?= tracker_top
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= Testbench passed
VFLAGS     ?= --assert --timing
LINT_FLAGS ?= -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# The run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
